// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = ddr_engine_tb
FILELIST = list.f

SRCS = $(wildcard hw/*.sv) $(wildcard test/*.sv)
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir

// ==== hw/ddr_engine_top.sv ====
`timescale 1ns/1ps

module ddr_engine_top #(
	parameter ddr_pkg::regf_addr_t P_WR_START_ADDR = 12'd1,
	parameter ddr_pkg::regf_addr_t P_RD_START_ADDR = 12'd10,
	parameter ddr_pkg::stall_cnt_t P_RESTART_STALL = 5'd10,
	parameter ddr_pkg::stall_cnt_t P_EXIT_STALL    = 5'd16
) (
	input  logic               i_sys_clk,
	input  logic               i_sys_rst,
	input  logic               i_engine_en,
	input  ddr_pkg::xfer_cfg_t   i_cfg,
	input  ddr_pkg::phy_status_t i_phy,
	input  logic               i_frmcnt_last,
	input  ddr_pkg::bit_cnt_t    i_bitcnt,
	output ddr_pkg::phy_ctrl_t   o_phy,
	output logic               o_frmcnt_en,
	output logic               o_bitcnt_en,
	output logic               o_bitcnt_rst,
	output logic               o_sclstall_en,
	output ddr_pkg::stall_cnt_t  o_sclstall_cycles,
	output ddr_pkg::regf_addr_t  o_regf_addr,
	output logic               o_regf_rd_en,
	output logic               o_regf_wr_en,
	output ddr_pkg::err_t        o_regf_error_type,
	output logic               o_regf_abort,
	output logic               o_engine_done
);
	import ddr_pkg::*;

	fsm_view_t view;  // state seen by both decoders

	ddr_frame_fsm ddr_frame_fsm_i (
		.i_sys_clk         (i_sys_clk),
		.i_sys_rst         (i_sys_rst),
		.i_engine_en       (i_engine_en),
		.i_cfg             (i_cfg),
		.i_phy             (i_phy),
		.i_frmcnt_last     (i_frmcnt_last),
		.o_view            (view),
		.o_regf_error_type (o_regf_error_type),
		.o_regf_abort      (o_regf_abort),
		.o_engine_done     (o_engine_done)
	);

	ddr_line_ctrl #(
		.P_RESTART_STALL (P_RESTART_STALL),
		.P_EXIT_STALL    (P_EXIT_STALL)
	) ddr_line_ctrl_i (
		.i_view            (view),
		.i_cfg             (i_cfg),
		.i_bitcnt          (i_bitcnt),
		.o_phy             (o_phy),
		.o_frmcnt_en       (o_frmcnt_en),
		.o_bitcnt_en       (o_bitcnt_en),
		.o_bitcnt_rst      (o_bitcnt_rst),
		.o_sclstall_en     (o_sclstall_en),
		.o_sclstall_cycles (o_sclstall_cycles)
	);

	ddr_regf_seq #(
		.P_WR_START_ADDR (P_WR_START_ADDR),
		.P_RD_START_ADDR (P_RD_START_ADDR)
	) ddr_regf_seq_i (
		.i_sys_clk    (i_sys_clk),
		.i_sys_rst    (i_sys_rst),
		.i_view       (view),
		.i_cfg        (i_cfg),
		.o_regf_addr  (o_regf_addr),
		.o_regf_rd_en (o_regf_rd_en),
		.o_regf_wr_en (o_regf_wr_en)
	);

endmodule

// ==== hw/ddr_frame_fsm.sv ====
`timescale 1ns/1ps

module ddr_frame_fsm (
	input  logic               i_sys_clk,
	input  logic               i_sys_rst,
	input  logic               i_engine_en,
	input  ddr_pkg::xfer_cfg_t   i_cfg,
	input  ddr_pkg::phy_status_t i_phy,
	input  logic               i_frmcnt_last,
	output ddr_pkg::fsm_view_t   o_view,
	output ddr_pkg::err_t        o_regf_error_type,
	output logic               o_regf_abort,
	output logic               o_engine_done
);
	import ddr_pkg::*;

	state_t state_q;
	state_t state_d;
	state_t end_state;    // restart or exit, by toc
	err_t   err_code;     // error type of the branch taken into st_error
	logic   ack_armed_q;
	logic   data_par_q;
	logic   phase_done;

	assign phase_done = i_phy.tx_done | i_phy.rx_done;  // either side ends the phase
	assign end_state  = i_cfg.toc ? st_exit : st_restart;

	always_comb
	begin
		state_d  = state_q;  // hold until the phase ends
		err_code = err_success;
		case (state_q)
			st_idle:
				if (i_engine_en)
					state_d = st_cmd_pre;
			st_cmd_pre:
				if (i_phy.tx_done)
					state_d = st_rnw_bit;
			st_rnw_bit:
				if (i_phy.tx_done)
					state_d = st_seven_zeros;
			st_seven_zeros:
				if (i_phy.tx_done)
					state_d = st_address;
			st_address:
				if (i_phy.tx_done)
					state_d = st_parity;
			st_parity:
				if (phase_done)
				begin
					if (!data_par_q)  // command parity, reads skip the ack
						state_d = i_cfg.rnw ? st_data_byte1 : st_ack_pre;
					else if (i_cfg.rnw && i_phy.rx_error)
					begin
						state_d  = st_error;
						err_code = err_parity;
					end
					else if (!i_cfg.rnw && i_frmcnt_last)
						state_d = st_crc_pre1;  // write has sent its last word
					else
						state_d = st_data_pre;
				end
			st_ack_pre:
				if (i_phy.tx_done)
					state_d = st_ack_wait;
			st_ack_wait:
				if (ack_armed_q && i_phy.rx_done)
				begin
					if (!i_phy.rx_pre)  // target pulls sda low to ack
						state_d = st_data_byte1;
					else
					begin
						state_d  = st_error;
						err_code = err_nack;
					end
				end
			st_data_byte1:
				if (phase_done)
					state_d = i_frmcnt_last ? st_zero_byte : st_data_byte2;
			st_data_byte2, st_zero_byte:
				if (phase_done)
					state_d = st_parity;
			st_data_pre:
				if (phase_done)
				begin
					if (!i_cfg.rnw || i_phy.rx_pre)
						state_d = st_abort_bit;  // another data word may follow
					else if (!i_frmcnt_last && i_cfg.short_read)
					begin
						state_d  = st_error;  // target stopped before the last word
						err_code = err_short_read;
					end
					else
						state_d = st_crc_pre2;
				end
			st_abort_bit:
				if (phase_done)
				begin
					// read continues until last, write continues while target holds 1
					if (i_cfg.rnw ? !i_frmcnt_last : i_phy.rx_pre)
						state_d = st_data_byte1;
					else
					begin
						state_d  = st_error;
						err_code = err_bus_abort;
					end
				end
			st_crc_pre1:
				if (phase_done)
					state_d = st_crc_pre2;
			st_crc_pre2:
				if (phase_done)
				begin
					if (i_cfg.rnw && !i_phy.rx_pre)  // preamble 00 is a broken frame
					begin
						state_d  = st_error;
						err_code = err_frame;
					end
					else
						state_d = st_token;
				end
			st_token:
				if (phase_done)
				begin
					if (i_cfg.rnw && i_phy.rx_error)
					begin
						state_d  = st_error;
						err_code = err_frame;
					end
					else
						state_d = st_crc_value;
				end
			st_crc_value:
				if (phase_done)
				begin
					if (i_cfg.rnw && i_phy.rx_error)
					begin
						state_d  = st_error;
						err_code = err_crc;
					end
					else
						state_d = end_state;
				end
			st_error:
				if (i_phy.rx_done)
					state_d = end_state;
			st_restart, st_exit:
				if (i_phy.tx_done)
					state_d = st_idle;
			default:
				state_d = st_idle;
		endcase
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			state_q           <= st_idle;
			ack_armed_q       <= 1'b0;
			data_par_q        <= 1'b0;
			o_regf_error_type <= err_success;
			o_regf_abort      <= 1'b0;
			o_engine_done     <= 1'b0;
		end
		else
		begin
			state_q     <= state_d;
			// one settle cycle in ack waiting, dropped on the way out
			ack_armed_q <= (state_q == st_ack_wait) && (state_d == st_ack_wait);
			if (state_q inside {st_idle, st_address})
				data_par_q <= 1'b0;  // command parity comes next
			else if (state_q inside {st_data_byte2, st_zero_byte})
				data_par_q <= 1'b1;
			if (state_q == st_idle && i_engine_en)
				o_regf_error_type <= err_success;  // new transfer
			else if (state_d == st_error && state_q != st_error)
				o_regf_error_type <= err_code;
			o_regf_abort  <= (state_q == st_abort_bit) && !i_cfg.rnw && phase_done &&
				!i_phy.rx_pre;  // target aborts the write
			o_engine_done <= (state_q inside {st_restart, st_exit}) && i_phy.tx_done;
		end
	end

	assign o_view.state     = state_q;
	assign o_view.ack_armed = ack_armed_q;
	assign o_view.data_par  = data_par_q;

endmodule

// ==== hw/ddr_line_ctrl.sv ====
`timescale 1ns/1ps

module ddr_line_ctrl #(
	parameter ddr_pkg::stall_cnt_t P_RESTART_STALL = 5'd10,
	parameter ddr_pkg::stall_cnt_t P_EXIT_STALL    = 5'd16
) (
	input  ddr_pkg::fsm_view_t  i_view,
	input  ddr_pkg::xfer_cfg_t  i_cfg,
	input  ddr_pkg::bit_cnt_t   i_bitcnt,
	output ddr_pkg::phy_ctrl_t  o_phy,
	output logic              o_frmcnt_en,
	output logic              o_bitcnt_en,
	output logic              o_bitcnt_rst,
	output logic              o_sclstall_en,
	output ddr_pkg::stall_cnt_t o_sclstall_cycles
);
	import ddr_pkg::*;

	tx_mode_t  tx_mode;
	rx_mode_t  rx_mode;
	dyn_addr_t tgt_addr;
	logic      rx_side;   // phase is driven by the target
	logic      active;
	logic      crc_stall; // stall window near the end of the crc

	assign tgt_addr = dyn_addr_t'(i_cfg.dev_index) + C_DEV_ADDR_BASE;
	// nothing on the line in idle or before the ack settle cycle
	assign active   = (i_view.state != st_idle) &&
		!(i_view.state == st_ack_wait && !i_view.ack_armed);

	always_comb
	begin
		case (i_view.state)
			st_rnw_bit:     tx_mode = i_cfg.rnw ? tx_one : tx_zero;
			st_seven_zeros: tx_mode = tx_seven_zeros;
			st_address:     tx_mode = tx_address;
			st_parity:      tx_mode = tx_parity;
			// read abort bit keeps the transfer going
			st_ack_pre, st_data_pre, st_crc_pre2, st_abort_bit: tx_mode = tx_one;
			st_data_byte1, st_data_byte2, st_zero_byte: tx_mode = tx_byte;
			st_crc_pre1:    tx_mode = tx_zero;
			st_token:       tx_mode = tx_token_crc;
			st_crc_value:   tx_mode = tx_crc_value;
			st_restart:     tx_mode = tx_restart;
			st_exit:        tx_mode = tx_exit;
			default:        tx_mode = tx_special_pre;  // command preamble
		endcase
		case (i_view.state)
			st_data_byte1, st_data_byte2, st_zero_byte: rx_mode = rx_byte;
			st_parity:      rx_mode = rx_parity_chk;
			st_token:       rx_mode = rx_token_chk;
			st_crc_value:   rx_mode = rx_crc_chk;
			st_error:       rx_mode = rx_err_mode;
			default:        rx_mode = rx_preamble;
		endcase
		case (i_view.state)
			st_ack_wait, st_error: rx_side = 1'b1;
			st_abort_bit:   rx_side = !i_cfg.rnw;  // write abort bit comes from target
			st_parity:      rx_side = i_cfg.rnw && i_view.data_par;  // data parity check
			st_data_byte1, st_data_byte2, st_zero_byte, st_data_pre, st_crc_pre2,
			st_token, st_crc_value: rx_side = i_cfg.rnw;
			default:        rx_side = 1'b0;
		endcase
	end

	always_comb
	begin
		o_phy.tx_en   = active && !rx_side;
		o_phy.tx_mode = tx_mode;
		o_phy.rx_en   = active && rx_side;
		o_phy.rx_mode = rx_mode;
		o_phy.tx_data = {1'b0, tgt_addr};  // only sent in st_address
	end

	assign crc_stall = (i_view.state == st_crc_value) &&
		(i_bitcnt == C_STALL_BIT_LO || i_bitcnt == C_STALL_BIT_HI);
	assign o_sclstall_en = crc_stall || (i_view.state inside {st_restart, st_exit});

	always_comb
	begin
		case (i_view.state)
			st_restart:   o_sclstall_cycles = P_RESTART_STALL;
			st_exit:      o_sclstall_cycles = P_EXIT_STALL;
			st_crc_value: o_sclstall_cycles = i_cfg.toc ? P_EXIT_STALL : P_RESTART_STALL;
			default:      o_sclstall_cycles = '0;
		endcase
	end

	// frame counter starts with the address byte
	assign o_frmcnt_en  = !(i_view.state inside {st_idle, st_cmd_pre, st_rnw_bit, st_seven_zeros});
	assign o_bitcnt_en  = (i_view.state != st_idle);
	assign o_bitcnt_rst = (i_view.state == st_error);  // realign after a bad frame

endmodule

// ==== hw/ddr_pkg.sv ====
package ddr_pkg;

	// widths with a meaning of their own
	typedef logic [4:0]  dev_index_t;  // device table index
	typedef logic [6:0]  dyn_addr_t;   // target address on the bus
	typedef logic [11:0] regf_addr_t;  // register file byte address
	typedef logic [4:0]  stall_cnt_t;  // scl stall length in scl cycles
	typedef logic [5:0]  bit_cnt_t;    // bit counter value

	// frame states of one ddr transfer
	typedef enum logic [4:0] {
		st_idle        = 5'd0,
		st_cmd_pre     = 5'd1,   // command preamble
		st_seven_zeros = 5'd2,
		st_address     = 5'd3,
		st_parity      = 5'd4,   // command or data parity
		st_ack_pre     = 5'd5,   // write only
		st_ack_wait    = 5'd6,
		st_data_byte1  = 5'd7,
		st_data_byte2  = 5'd8,
		st_data_pre    = 5'd9,   // preamble between data words
		st_abort_bit   = 5'd10,
		st_crc_pre1    = 5'd11,
		st_crc_pre2    = 5'd12,
		st_token       = 5'd13,
		st_crc_value   = 5'd14,
		st_error       = 5'd15,
		st_restart     = 5'd16,
		st_exit        = 5'd17,
		st_rnw_bit     = 5'd18,
		st_zero_byte   = 5'd19   // dummy byte for an odd count
	} state_t;

	// serializer codes, same encoding as the phy side
	typedef enum logic [3:0] {
		tx_special_pre = 4'b0000,
		tx_address     = 4'b0001,
		tx_one         = 4'b0010,
		tx_seven_zeros = 4'b0011,
		tx_parity      = 4'b0100,
		tx_zero        = 4'b0110,
		tx_byte        = 4'b0111,
		tx_token_crc   = 4'b1100,
		tx_crc_value   = 4'b1101,
		tx_exit        = 4'b1110,
		tx_restart     = 4'b1111
	} tx_mode_t;

	// deserializer codes
	typedef enum logic [3:0] {
		rx_preamble   = 4'd0,
		rx_byte       = 4'd3,
		rx_token_chk  = 4'd4,
		rx_parity_chk = 4'd5,
		rx_crc_chk    = 4'd6,
		rx_err_mode   = 4'd7
	} rx_mode_t;

	typedef enum logic [3:0] {
		err_success    = 4'd0,
		err_crc        = 4'd1,
		err_parity     = 4'd2,
		err_frame      = 4'd3,
		err_nack       = 4'd5,
		err_short_read = 4'd7,
		err_bus_abort  = 4'd9
	} err_t;

	typedef struct packed {
		logic       toc;        // 1 stop, 0 restart
		dev_index_t dev_index;
		logic       short_read; // early end of a read is an error
		logic       rnw;        // 1 read, 0 write
	} xfer_cfg_t;

	typedef struct packed {
		logic tx_done;
		logic rx_done;
		logic rx_pre;           // valid with rx_done
		logic rx_error;         // valid with rx_done
	} phy_status_t;

	typedef struct packed {
		logic       tx_en;
		tx_mode_t   tx_mode;
		logic       rx_en;
		rx_mode_t   rx_mode;
		logic [7:0] tx_data;
	} phy_ctrl_t;

	typedef struct packed {
		state_t state;
		logic   ack_armed;      // ack sampling window open
		logic   data_par;       // next parity covers data
	} fsm_view_t;

	localparam dyn_addr_t C_DEV_ADDR_BASE = 7'd8;  // first dynamic address
	localparam bit_cnt_t  C_STALL_BIT_LO  = 6'd11;
	localparam bit_cnt_t  C_STALL_BIT_HI  = 6'd12;

endpackage

// ==== hw/ddr_regf_seq.sv ====
`timescale 1ns/1ps

module ddr_regf_seq #(
	parameter ddr_pkg::regf_addr_t P_WR_START_ADDR = 12'd1,
	parameter ddr_pkg::regf_addr_t P_RD_START_ADDR = 12'd10
) (
	input  logic              i_sys_clk,
	input  logic              i_sys_rst,
	input  ddr_pkg::fsm_view_t  i_view,
	input  ddr_pkg::xfer_cfg_t  i_cfg,
	output ddr_pkg::regf_addr_t o_regf_addr,
	output logic              o_regf_rd_en,
	output logic              o_regf_wr_en
);
	import ddr_pkg::*;

	state_t     prev_state_q;
	regf_addr_t addr_q;
	logic       in_byte;    // a real data byte is on the line
	logic       byte_done;  // first cycle after a data byte state

	assign in_byte   = i_view.state inside {st_data_byte1, st_data_byte2};
	assign byte_done = (prev_state_q inside {st_data_byte1, st_data_byte2}) &&
		(i_view.state != prev_state_q);

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			prev_state_q <= st_idle;
			addr_q       <= '0;
		end
		else
		begin
			prev_state_q <= i_view.state;
			if (i_view.state == st_idle)
				addr_q <= i_cfg.rnw ? P_RD_START_ADDR : P_WR_START_ADDR;  // reload per transfer
			else if (byte_done)
				addr_q <= addr_q + 12'd1;
		end
	end

	assign o_regf_addr  = addr_q;
	assign o_regf_rd_en = in_byte && !i_cfg.rnw;  // write pulls bytes from the regfile
	assign o_regf_wr_en = in_byte && i_cfg.rnw;   // read stores received bytes

endmodule

// ==== list.f ====
hw/ddr_pkg.sv
hw/ddr_frame_fsm.sv
hw/ddr_line_ctrl.sv
hw/ddr_regf_seq.sv
hw/ddr_engine_top.sv
test/ddr_engine_chk.sv
test/ddr_engine_tb.sv

// ==== test/ddr_engine_chk.sv ====
`timescale 1ns/1ps

module ddr_engine_chk (
	input logic i_sys_clk,
	input logic i_sys_rst,
	input logic i_tx_en,
	input logic i_rx_en,
	input logic i_regf_rd_en,
	input logic i_regf_wr_en,
	input logic i_engine_done
);

	// one side of the line at a time
	tx_rx_excl: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!(i_tx_en && i_rx_en))
		else $error("tx and rx enabled in the same cycle");

	strobe_excl: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		!($rose(i_regf_rd_en) && $rose(i_regf_wr_en)))
		else $error("regfile read and write strobes rose together");

	done_pulse: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		i_engine_done |=> !i_engine_done)
		else $error("engine done longer than one cycle");

endmodule

bind ddr_engine_top ddr_engine_chk ddr_engine_chk_i (
	.i_sys_clk     (i_sys_clk),
	.i_sys_rst     (i_sys_rst),
	.i_tx_en       (o_phy.tx_en),
	.i_rx_en       (o_phy.rx_en),
	.i_regf_rd_en  (o_regf_rd_en),
	.i_regf_wr_en  (o_regf_wr_en),
	.i_engine_done (o_engine_done)
);

// ==== test/ddr_engine_tb.sv ====
`timescale 1ns/1ps

module ddr_engine_tb;
	import ddr_pkg::*;

	localparam int C_CLK_PERIOD    = 8;
	localparam int C_RESP_DELAY    = 4;   // phy answers 4 cycles after an enable
	localparam int C_MAX_PHASES    = 30;  // longest frame, 6 bytes with crc and end
	localparam int C_CYC_PER_PHASE = 40;
	localparam int C_NUM_TESTS     = 6;
	localparam int C_XFER_CYCLES   = C_MAX_PHASES * C_CYC_PER_PHASE;

	logic        i_sys_clk = 1'b0;
	logic        i_sys_rst = 1'b0;
	logic        i_engine_en = 1'b0;
	xfer_cfg_t   i_cfg = '0;
	phy_status_t phy_sts = '0;        // owned by the phy responder
	logic        frmcnt_last = 1'b0;  // owned by the phy responder
	bit_cnt_t    i_bitcnt = '0;       // owned by the phy responder

	phy_ctrl_t  o_phy;
	logic       o_frmcnt_en;
	logic       o_bitcnt_en;
	logic       o_bitcnt_rst;
	logic       o_sclstall_en;
	stall_cnt_t o_sclstall_cycles;
	regf_addr_t o_regf_addr;
	logic       o_regf_rd_en;
	logic       o_regf_wr_en;
	err_t       o_regf_error_type;
	logic       o_regf_abort;
	logic       o_engine_done;

	// scripted phy behaviour, set per test
	int   nbytes = 2;
	logic nack_resp = 1'b0;   // target does not ack the write
	logic crc_resp = 1'b0;    // bad crc on a read
	logic early_stop = 1'b0;  // target ends the read after the first pair

	// what the responder saw during the transfer
	int         wait_cnt = 0;
	int         bytes_done = 0;
	state_t     cur_state;
	phy_status_t sts;
	tx_mode_t   tx_log[$];
	regf_addr_t rd_log[$];
	regf_addr_t wr_log[$];
	logic [7:0] addr_seen;
	tx_mode_t   end_mode;
	stall_cnt_t end_stall;
	logic       end_stall_en;
	logic       crc_stall_en;   // stall request inside the crc window
	stall_cnt_t crc_stall_len;
	rx_mode_t   err_rx_mode;
	logic       err_bitcnt_rst;
	logic       err_seen;

	int mismatches = 0;
	int other_errs = 0;

	ddr_engine_top #(
		.P_WR_START_ADDR (12'd1),
		.P_RD_START_ADDR (12'd10),
		.P_RESTART_STALL (5'd10),
		.P_EXIT_STALL    (5'd16)
	) ddr_engine_top_i (
		.i_sys_clk         (i_sys_clk),
		.i_sys_rst         (i_sys_rst),
		.i_engine_en       (i_engine_en),
		.i_cfg             (i_cfg),
		.i_phy             (phy_sts),
		.i_frmcnt_last     (frmcnt_last),
		.i_bitcnt          (i_bitcnt),
		.o_phy             (o_phy),
		.o_frmcnt_en       (o_frmcnt_en),
		.o_bitcnt_en       (o_bitcnt_en),
		.o_bitcnt_rst      (o_bitcnt_rst),
		.o_sclstall_en     (o_sclstall_en),
		.o_sclstall_cycles (o_sclstall_cycles),
		.o_regf_addr       (o_regf_addr),
		.o_regf_rd_en      (o_regf_rd_en),
		.o_regf_wr_en      (o_regf_wr_en),
		.o_regf_error_type (o_regf_error_type),
		.o_regf_abort      (o_regf_abort),
		.o_engine_done     (o_engine_done)
	);

	initial
	begin
		forever
			#(C_CLK_PERIOD / 2) i_sys_clk = ~i_sys_clk;
	end

	initial
	begin
		#(C_NUM_TESTS * C_XFER_CYCLES * C_CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	assign cur_state = ddr_engine_top_i.view.state;  // phy model peeks at the phase

	// phy responder: one done pulse per phase, C_RESP_DELAY cycles after the enable
	always @(posedge i_sys_clk)
	begin
		sts = '0;
		if (!i_sys_rst)
		begin
			phy_sts  <= '0;
			wait_cnt <= 0;
		end
		else if (phy_sts.tx_done || phy_sts.rx_done)
		begin
			phy_sts  <= '0;  // dut moves on this edge
			wait_cnt <= 0;
		end
		else if (o_phy.tx_en || o_phy.rx_en)
		begin
			if (wait_cnt == C_RESP_DELAY - 1)
			begin
				if (o_phy.tx_en)
					sts.tx_done = 1'b1;
				else
					sts.rx_done = 1'b1;
				case (cur_state)
					st_ack_wait:  sts.rx_pre = nack_resp;
					st_abort_bit: sts.rx_pre = 1'b1;     // write keeps going
					st_data_pre:  sts.rx_pre = i_cfg.rnw && !early_stop && bytes_done < nbytes;
					st_crc_pre2:  sts.rx_pre = 1'b1;
					st_crc_value: sts.rx_error = crc_resp;
					default:      sts.rx_pre = 1'b0;
				endcase
				if (o_phy.tx_en)
					tx_log.push_back(o_phy.tx_mode);
				if (o_regf_rd_en)
					rd_log.push_back(o_regf_addr);
				if (o_regf_wr_en)
					wr_log.push_back(o_regf_addr);
				if (cur_state == st_address)
					addr_seen = o_phy.tx_data;
				if (cur_state == st_crc_value)
				begin
					crc_stall_en  = o_sclstall_en;
					crc_stall_len = o_sclstall_cycles;
				end
				if (cur_state inside {st_restart, st_exit})
				begin
					end_mode     = o_phy.tx_mode;
					end_stall    = o_sclstall_cycles;
					end_stall_en = o_sclstall_en;
				end
				if (cur_state == st_error)
				begin
					err_rx_mode    = o_phy.rx_mode;
					err_bitcnt_rst = o_bitcnt_rst;
					err_seen       = 1'b1;
				end
				if (cur_state inside {st_data_byte1, st_data_byte2})
				begin
					bytes_done  <= bytes_done + 1;
					frmcnt_last <= (bytes_done + 1 >= nbytes);  // final pair sent
				end
				phy_sts  <= sts;
				wait_cnt <= 0;
			end
			else
				wait_cnt <= wait_cnt + 1;
		end
		else
			wait_cnt <= 0;
		// bit counter sits at bit 11 for the whole crc value phase
		i_bitcnt <= (cur_state == st_crc_value) ? 6'd11 : 6'd0;
		if (cur_state == st_idle)
		begin
			bytes_done  <= 0;
			frmcnt_last <= 1'b0;
			if (i_engine_en)  // fresh transfer, drop old records
			begin
				tx_log.delete();
				rd_log.delete();
				wr_log.delete();
				err_seen     = 1'b0;
				crc_stall_en = 1'b0;
				end_mode     = tx_special_pre;
			end
		end
	end

	task automatic check_mode(input string name, input tx_mode_t got, input tx_mode_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_rx_mode(input string name, input rx_mode_t got, input rx_mode_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_err(input string name, input err_t got, input err_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input regf_addr_t got, input regf_addr_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_stall(input string name, input stall_cnt_t got, input stall_cnt_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// even byte count, 2 to 6 or 4 to 6
	function automatic int pick_bytes(input int min_pairs);
		return 2 * int'($urandom_range(3, min_pairs));
	endfunction

	task automatic run_transfer(input logic rnw, input logic toc, input logic short_rd,
		input dev_index_t dev);
		int cyc;
		cyc = 0;
		@(posedge i_sys_clk);
		i_cfg.rnw        <= rnw;
		i_cfg.toc        <= toc;
		i_cfg.short_read <= short_rd;
		i_cfg.dev_index  <= dev;
		@(posedge i_sys_clk);
		i_engine_en <= 1'b1;
		@(posedge i_sys_clk);
		i_engine_en <= 1'b0;
		while (!o_engine_done && cyc < C_XFER_CYCLES)
		begin
			@(posedge i_sys_clk);
			cyc++;
		end
		if (!o_engine_done)
		begin
			other_errs++;
			$display("transfer did not finish, engine done never came");
		end
	endtask

	// one strobe per byte, counting up from the start address
	task automatic check_strobes(input regf_addr_t start, input int exp_cnt, input logic rd);
		regf_addr_t got_q[$];
		if (rd)
			got_q = rd_log;
		else
			got_q = wr_log;
		if (got_q.size() != exp_cnt)
		begin
			other_errs++;
			$display("wrong number of %s strobes, saw %0d and wanted %0d",
				rd ? "read" : "write", got_q.size(), exp_cnt);
		end
		foreach (got_q[i])
			check_addr("o_regf_addr", got_q[i], start + regf_addr_t'(i));
	endtask

	task automatic test_reset();
		check_bit("o_phy.tx_en", o_phy.tx_en, 1'b0);
		check_bit("o_phy.rx_en", o_phy.rx_en, 1'b0);
		check_bit("o_frmcnt_en", o_frmcnt_en, 1'b0);
		check_bit("o_bitcnt_en", o_bitcnt_en, 1'b0);
		check_bit("o_regf_rd_en", o_regf_rd_en, 1'b0);
		check_bit("o_regf_wr_en", o_regf_wr_en, 1'b0);
		check_bit("o_sclstall_en", o_sclstall_en, 1'b0);
		check_bit("o_regf_abort", o_regf_abort, 1'b0);
		check_bit("o_engine_done", o_engine_done, 1'b0);
		check_err("o_regf_error_type", o_regf_error_type, err_success);
	endtask

	task automatic test_write_stop();
		dev_index_t dev;
		dev        = 5'd5;
		nbytes     = pick_bytes(1);
		nack_resp  = 1'b0;
		crc_resp   = 1'b0;
		early_stop = 1'b0;
		run_transfer(1'b0, 1'b1, 1'b0, dev);
		if (tx_log.size() < 5)
		begin
			other_errs++;
			$display("write frame sent fewer than five command phases");
		end
		else
		begin
			check_mode("tx_mode[0]", tx_log[0], tx_special_pre);
			check_mode("tx_mode[1]", tx_log[1], tx_zero);  // rnw bit of a write
			check_mode("tx_mode[2]", tx_log[2], tx_seven_zeros);
			check_mode("tx_mode[3]", tx_log[3], tx_address);
			check_mode("tx_mode[4]", tx_log[4], tx_parity);
		end
		check_byte("o_phy.tx_data", addr_seen, 8'h0d);  // device 5 sits at address 13
		check_strobes(12'd1, nbytes, 1'b1);
		check_strobes(12'd1, 0, 1'b0);
		check_bit("o_sclstall_en", crc_stall_en, 1'b1);  // crc window at bit 11
		check_stall("o_sclstall_cycles", crc_stall_len, 5'd16);
		check_mode("end tx_mode", end_mode, tx_exit);
		check_stall("o_sclstall_cycles", end_stall, 5'd16);
		check_bit("o_sclstall_en", end_stall_en, 1'b1);
		check_err("o_regf_error_type", o_regf_error_type, err_success);
	endtask

	task automatic test_read_restart();
		nbytes     = pick_bytes(1);
		nack_resp  = 1'b0;
		crc_resp   = 1'b0;
		early_stop = 1'b0;
		run_transfer(1'b1, 1'b0, 1'b0, 5'd2);
		check_strobes(12'd10, nbytes, 1'b0);
		check_strobes(12'd10, 0, 1'b1);
		check_bit("o_sclstall_en", crc_stall_en, 1'b1);
		check_stall("o_sclstall_cycles", crc_stall_len, 5'd10);
		check_mode("end tx_mode", end_mode, tx_restart);
		check_stall("o_sclstall_cycles", end_stall, 5'd10);
		check_bit("o_sclstall_en", end_stall_en, 1'b1);
		check_err("o_regf_error_type", o_regf_error_type, err_success);
	endtask

	task automatic test_write_nack();
		nbytes     = pick_bytes(1);
		nack_resp  = 1'b1;
		crc_resp   = 1'b0;
		early_stop = 1'b0;
		run_transfer(1'b0, 1'b1, 1'b0, 5'd9);
		check_err("o_regf_error_type", o_regf_error_type, err_nack);
		if (!err_seen)
		begin
			other_errs++;
			$display("nack did not pass through the error state");
		end
		check_rx_mode("o_phy.rx_mode", err_rx_mode, rx_err_mode);
		check_bit("o_bitcnt_rst", err_bitcnt_rst, 1'b1);
		check_strobes(12'd1, 0, 1'b1);  // no byte was fetched
		check_mode("end tx_mode", end_mode, tx_exit);
		nack_resp = 1'b0;
	endtask

	task automatic test_read_crc();
		nbytes     = pick_bytes(1);
		crc_resp   = 1'b1;
		early_stop = 1'b0;
		run_transfer(1'b1, 1'b1, 1'b0, 5'd3);
		check_err("o_regf_error_type", o_regf_error_type, err_crc);
		check_strobes(12'd10, nbytes, 1'b0);
		check_mode("end tx_mode", end_mode, tx_exit);
		crc_resp = 1'b0;
	endtask

	task automatic test_read_short();
		nbytes     = pick_bytes(2);  // early end needs a later pair
		crc_resp   = 1'b0;
		early_stop = 1'b1;
		run_transfer(1'b1, 1'b0, 1'b1, 5'd4);
		check_err("o_regf_error_type", o_regf_error_type, err_short_read);
		check_strobes(12'd10, 2, 1'b0);  // only the first pair arrived
		check_mode("end tx_mode", end_mode, tx_restart);
		early_stop = 1'b0;
	endtask

	initial
	begin
		void'($urandom(28));
		repeat (3) @(posedge i_sys_clk);
		i_sys_rst <= 1'b1;
		repeat (2) @(posedge i_sys_clk);
		test_reset();
		test_write_stop();
		test_read_restart();
		test_write_nack();
		test_read_crc();
		test_read_short();
		repeat (4) @(posedge i_sys_clk);
		$display("errors: mismatches %0d, other failures %0d", mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
